//--- flist.f
design/l2_cache_pkg.sv
design/tag_if.sv
design/tag_store.sv
design/data_store.sv
design/cache_ctrl.sv
design/l2_cache.sv
tests/l2_cache_asserts.sv
tests/l2_cache_tb.sv

//--- tests/l2_cache_tb.sv
`timescale 1ns/100ps

module l2_cache_tb;

    localparam int num_tests   = 10;
    localparam int cycle_limit = num_tests * 15;

    logic                             clk;
    logic                             n_reset;
    logic                             l1_read;
    logic                             l1_write;
    logic [l2_cache_pkg::addr_w-1:0]  l1_addr;
    logic [l2_cache_pkg::block_w-1:0] l1_wdata;
    logic                             l1_ready;
    logic [l2_cache_pkg::block_w-1:0] l1_rdata;
    logic                             mem_read;
    logic                             mem_write;
    logic [l2_cache_pkg::addr_w-1:0]  mem_addr;
    logic [l2_cache_pkg::block_w-1:0] mem_wdata;
    logic [l2_cache_pkg::block_w-1:0] mem_rdata;
    logic                             mem_ready;

    integer seed = 44757;
    logic [31:0] salt [4];

    // memory model state
    logic [l2_cache_pkg::block_w-1:0] shadow_mem [logic [l2_cache_pkg::addr_w-1:0]];
    logic                             mem_busy;
    logic                             mem_op_write;
    int                               mem_wait;
    logic [l2_cache_pkg::addr_w-1:0]  mem_req_addr;
    logic [l2_cache_pkg::block_w-1:0] mem_req_data;
    int                               n_wb;
    int                               n_fill;
    logic [l2_cache_pkg::addr_w-1:0]  last_wb_addr;
    logic [l2_cache_pkg::block_w-1:0] last_wb_data;
    logic [l2_cache_pkg::addr_w-1:0]  last_fill_addr;

    // reference model of the cache
    logic [l2_cache_pkg::block_w-1:0] model_mem [logic [l2_cache_pkg::addr_w-1:0]];
    logic                             model_valid [l2_cache_pkg::num_lines];
    logic                             model_dirty [l2_cache_pkg::num_lines];
    logic [l2_cache_pkg::tag_w-1:0]   model_tag [l2_cache_pkg::num_lines];
    logic [l2_cache_pkg::block_w-1:0] model_data [l2_cache_pkg::num_lines];

    // stimulus table, expected columns filled by the model
    string                            test_name [num_tests];
    logic                             is_write [num_tests];
    logic [l2_cache_pkg::addr_w-1:0]  addrs [num_tests];
    logic [l2_cache_pkg::block_w-1:0] wdata [num_tests];
    logic [l2_cache_pkg::block_w-1:0] exp_rdata [num_tests];
    int                               exp_traffic [num_tests];  // 0 none, 1 fill, 2 wb + fill
    logic [l2_cache_pkg::addr_w-1:0]  exp_wb_addr [num_tests];
    logic [l2_cache_pkg::block_w-1:0] exp_wb_data [num_tests];

    int num_entries;
    int cycles;
    int test_errors;
    int total_errors;
    int tests_failed;

    l2_cache dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // initial memory contents, every address bit matters
    function automatic logic [l2_cache_pkg::block_w-1:0] mem_pattern(
        input logic [l2_cache_pkg::addr_w-1:0] a);
        return {salt[0] ^ {4'h1, a}, salt[1] ^ {4'h2, a}, salt[2] ^ {4'h3, a}, salt[3] ^ {4'h4, a}};
    endfunction

    function automatic logic [l2_cache_pkg::block_w-1:0] shadow_block(
        input logic [l2_cache_pkg::addr_w-1:0] a);
        return shadow_mem.exists(a) ? shadow_mem[a] : mem_pattern(a);
    endfunction

    function automatic logic [l2_cache_pkg::block_w-1:0] model_block(
        input logic [l2_cache_pkg::addr_w-1:0] a);
        return model_mem.exists(a) ? model_mem[a] : mem_pattern(a);
    endfunction

    task automatic add_test(input string name, input logic wr, input logic [27:0] a);
        test_name[num_entries] = name;
        is_write[num_entries]  = wr;
        addrs[num_entries]     = a;
        wdata[num_entries]     = {$random(seed), $random(seed), $random(seed), $random(seed)};
        num_entries++;
    endtask

    // direct-mapped write-back, write-allocate rules
    task automatic predict_entry(input int i);
        logic [l2_cache_pkg::index_w-1:0] idx;
        logic [l2_cache_pkg::tag_w-1:0]   tg;
        idx = addrs[i][l2_cache_pkg::index_w-1:0];
        tg  = addrs[i][l2_cache_pkg::addr_w-1:l2_cache_pkg::index_w];
        exp_traffic[i] = 0;
        exp_wb_addr[i] = '0;
        exp_wb_data[i] = '0;
        if (!(model_valid[idx] && model_tag[idx] == tg)) begin
            exp_traffic[i] = 1;
            if (model_valid[idx] && model_dirty[idx]) begin
                exp_traffic[i] = 2;
                exp_wb_addr[i] = {model_tag[idx], idx};
                exp_wb_data[i] = model_data[idx];
                model_mem[{model_tag[idx], idx}] = model_data[idx];
            end
            model_data[idx]  = model_block(addrs[i]);
            model_valid[idx] = 1'b1;
            model_dirty[idx] = 1'b0;
            model_tag[idx]   = tg;
        end
        if (is_write[i]) begin
            model_data[idx]  = wdata[i];
            model_dirty[idx] = 1'b1;
        end
        exp_rdata[i] = model_data[idx];
    endtask

    task automatic expect_value(input string name, input string what,
                                input logic [127:0] expected, input logic [127:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", name, what, expected, actual);
            test_errors++;
        end
    endtask

    // memory takes the request seen before the edge
    always @(posedge clk) begin
        if (!mem_ready && !mem_busy && (mem_read || mem_write)) begin
            mem_busy     = 1'b1;
            mem_op_write = mem_write;
            mem_req_addr = mem_addr;
            mem_req_data = mem_wdata;
            mem_wait     = ($random(seed) & 3) + 1;
        end
    end

    always @(negedge clk) begin
        if (mem_ready) begin
            mem_ready = 1'b0;               // one-cycle pulse
        end else if (mem_busy) begin
            mem_wait = mem_wait - 1;
            if (mem_wait == 0) begin
                if (mem_op_write) begin
                    shadow_mem[mem_req_addr] = mem_req_data;
                    last_wb_addr = mem_req_addr;
                    last_wb_data = mem_req_data;
                    n_wb++;
                end else begin
                    mem_rdata      = shadow_block(mem_req_addr);
                    last_fill_addr = mem_req_addr;
                    n_fill++;
                end
                mem_busy  = 1'b0;
                mem_ready = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (!n_reset) begin
            cycles++;
        end
        if (cycles > cycle_limit) begin
            $display("cache never answered a request within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int waited;
        logic [l2_cache_pkg::block_w-1:0] got;
        n_reset   = 1'b1;
        l1_read   = 1'b0;
        l1_write  = 1'b0;
        l1_addr   = '0;
        l1_wdata  = '0;
        mem_rdata = '0;
        mem_ready = 1'b0;
        mem_busy  = 1'b0;
        cycles    = 0;
        for (int k = 0; k < 4; k++) begin
            salt[k] = $random(seed);
        end
        for (int k = 0; k < l2_cache_pkg::num_lines; k++) begin
            model_valid[k] = 1'b0;
            model_dirty[k] = 1'b0;
            model_tag[k]   = '0;
            model_data[k]  = '0;
        end
        add_test("cold_read_miss",   1'b0, {21'h00abc, 7'h15});
        add_test("read_hit",         1'b0, {21'h00abc, 7'h15});
        add_test("write_hit",        1'b1, {21'h00abc, 7'h15});
        add_test("read_after_write", 1'b0, {21'h00abc, 7'h15});
        add_test("dirty_conflict",   1'b0, {21'h01234, 7'h15});
        add_test("clean_conflict",   1'b0, {21'h1f00f, 7'h15});
        add_test("write_miss",       1'b1, {21'h00abc, 7'h6a});
        add_test("read_write_miss",  1'b0, {21'h00abc, 7'h6a});
        add_test("evict_write_miss", 1'b0, {21'h01234, 7'h6a});
        add_test("refetch_victim",   1'b0, {21'h00abc, 7'h15});
        for (int i = 0; i < num_entries; i++) begin
            predict_entry(i);
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        n_reset = 1'b0;

        for (int i = 0; i < num_entries; i++) begin
            @(negedge clk);
            test_errors = 0;
            n_wb        = 0;
            n_fill      = 0;
            l1_addr     = addrs[i];
            l1_wdata    = wdata[i];
            l1_read     = !is_write[i];
            l1_write    = is_write[i];
            waited      = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!l1_ready);
            got      = l1_rdata;
            l1_read  = 1'b0;
            l1_write = 1'b0;

            if (!is_write[i]) begin
                expect_value(test_name[i], "read data", exp_rdata[i], got);
            end
            expect_value(test_name[i], "fill count", (exp_traffic[i] > 0), n_fill);
            expect_value(test_name[i], "write-back count", (exp_traffic[i] == 2), n_wb);
            if (exp_traffic[i] == 0) begin
                expect_value(test_name[i], "hit latency", 1, waited);
            end else if (n_fill == 1) begin
                expect_value(test_name[i], "fill address", addrs[i], last_fill_addr);
            end
            if (exp_traffic[i] == 2 && n_wb == 1) begin
                expect_value(test_name[i], "write-back address", exp_wb_addr[i], last_wb_addr);
                expect_value(test_name[i], "write-back data", exp_wb_data[i], last_wb_data);
            end

            if (test_errors == 0) begin
                $display("test %-18s ok", test_name[i]);
            end else begin
                $display("test %-18s %0d errors", test_name[i], test_errors);
                tests_failed++;
            end
            total_errors += test_errors;
        end

        $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
                 num_entries, tests_failed, total_errors, dut.u_asserts.fail_count);
        if (total_errors == 0 && dut.u_asserts.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- tests/l2_cache_asserts.sv
`timescale 1ns/100ps

module l2_cache_asserts (
    input logic                            clk,
    input logic                            n_reset,
    input logic                            l1_read,
    input logic                            l1_write,
    input logic                            l1_ready,
    input logic                            mem_read,
    input logic                            mem_write,
    input logic [l2_cache_pkg::addr_w-1:0] mem_addr,
    input logic                            mem_ready
);

    int fail_count = 0;     // failed assertions so far

    mem_exclusive: assert property (@(posedge clk) disable iff (n_reset)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write high together");
            fail_count++;
        end

    // request level and address held until memory answers
    read_held: assert property (@(posedge clk) disable iff (n_reset)
        (mem_read && !mem_ready) |=> (mem_read && $stable(mem_addr)))
        else begin
            $error("mem_read dropped or mem_addr moved before mem_ready");
            fail_count++;
        end

    write_held: assert property (@(posedge clk) disable iff (n_reset)
        (mem_write && !mem_ready) |=> (mem_write && $stable(mem_addr)))
        else begin
            $error("mem_write dropped or mem_addr moved before mem_ready");
            fail_count++;
        end

    ready_after_request: assert property (@(posedge clk) disable iff (n_reset)
        l1_ready |-> $past(l1_read ^ l1_write))
        else begin
            $error("l1_ready without a request in the cycle before");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        n_reset |-> (!l1_ready && !mem_read && !mem_write))
        else begin
            $error("outputs active during reset");
            fail_count++;
        end

endmodule

bind l2_cache l2_cache_asserts u_asserts (.*);

//--- design/l2_cache.sv
`timescale 1ns/100ps

module l2_cache (
    input  logic                             clk,
    input  logic                             n_reset,

    // requester side
    input  logic                             l1_read,
    input  logic                             l1_write,
    input  logic [l2_cache_pkg::addr_w-1:0]  l1_addr,
    input  logic [l2_cache_pkg::block_w-1:0] l1_wdata,
    output logic                             l1_ready,
    output logic [l2_cache_pkg::block_w-1:0] l1_rdata,

    // memory side
    output logic                             mem_read,
    output logic                             mem_write,
    output logic [l2_cache_pkg::addr_w-1:0]  mem_addr,
    output logic [l2_cache_pkg::block_w-1:0] mem_wdata,
    input  logic [l2_cache_pkg::block_w-1:0] mem_rdata,
    input  logic                             mem_ready
);

    l2_cache_pkg::block_addr_u req_addr;

    logic wr_en;
    logic fill_sel;
    logic rd_capture;

    tag_if tags ();

    assign req_addr = l1_addr;      // split for the stores

    cache_ctrl u_ctrl (
        .clk        (clk),
        .n_reset    (n_reset),
        .l1_read    (l1_read),
        .l1_write   (l1_write),
        .l1_addr    (l1_addr),
        .mem_ready  (mem_ready),
        .tags       (tags),
        .l1_ready   (l1_ready),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .wr_en      (wr_en),
        .fill_sel   (fill_sel),
        .rd_capture (rd_capture)
    );

    tag_store u_tag_store (
        .clk     (clk),
        .n_reset (n_reset),
        .index   (req_addr.fields.index),
        .tag     (req_addr.fields.tag),
        .tags    (tags)
    );

    // the indexed line doubles as write-back data
    data_store u_data_store (
        .clk        (clk),
        .index      (req_addr.fields.index),
        .wr_en      (wr_en),
        .fill_sel   (fill_sel),
        .l1_wdata   (l1_wdata),
        .mem_rdata  (mem_rdata),
        .rd_capture (rd_capture),
        .line       (mem_wdata),
        .l1_rdata   (l1_rdata)
    );

endmodule

//--- design/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                            clk,
    input  logic                            n_reset,
    input  logic                            l1_read,
    input  logic                            l1_write,
    input  logic [l2_cache_pkg::addr_w-1:0] l1_addr,
    input  logic                            mem_ready,
    tag_if.ctrl                             tags,
    output logic                            l1_ready,
    output logic                            mem_read,
    output logic                            mem_write,
    output logic [l2_cache_pkg::addr_w-1:0] mem_addr,
    output logic                            wr_en,
    output logic                            fill_sel,
    output logic                            rd_capture
);

    l2_cache_pkg::ctrl_state_t state;
    l2_cache_pkg::ctrl_state_t next_state;
    l2_cache_pkg::block_addr_u req_addr;
    l2_cache_pkg::block_addr_u wb_addr;

    logic read_req;
    logic write_req;
    logic lookup;
    logic rd_hit;
    logic wr_hit;
    logic dirty_miss;
    logic fill_done;

    // exactly one of read or write makes a request
    assign read_req  = l1_read && !l1_write;
    assign write_req = l1_write && !l1_read;
    assign lookup    = (state == l2_cache_pkg::compare) && (read_req || write_req);

    assign rd_hit     = lookup && read_req && tags.hit;
    assign wr_hit     = lookup && write_req && tags.hit;
    assign dirty_miss = tags.line_valid && tags.line_dirty;
    assign fill_done  = (state == l2_cache_pkg::fill) && mem_ready;

    // victim address is the stored tag over the request index
    assign req_addr                = l1_addr;
    assign wb_addr.fields.tag      = tags.victim_tag;
    assign wb_addr.fields.index    = req_addr.fields.index;

    // store strobes
    assign rd_capture     = rd_hit;
    assign wr_en          = wr_hit || fill_done;
    assign fill_sel       = (state == l2_cache_pkg::fill);
    assign tags.set_dirty = wr_hit;
    assign tags.fill_en   = fill_done;

    always_comb begin
        next_state = state;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_addr   = req_addr.flat;
        case (state)
            l2_cache_pkg::compare: begin
                if (lookup && !tags.hit) begin
                    if (dirty_miss) begin
                        mem_write  = 1'b1;
                        mem_addr   = wb_addr.flat;
                        next_state = l2_cache_pkg::write_back;
                    end else begin
                        mem_read   = 1'b1;
                        next_state = l2_cache_pkg::fill;
                    end
                end
            end
            l2_cache_pkg::write_back: begin
                mem_write = 1'b1;           // held until mem_ready sampled
                mem_addr  = wb_addr.flat;
                if (mem_ready) begin
                    next_state = l2_cache_pkg::fill;    // straight into the read
                end
            end
            l2_cache_pkg::fill: begin
                mem_read = 1'b1;
                if (mem_ready) begin
                    next_state = l2_cache_pkg::compare; // request hits there
                end
            end
            default: begin
                next_state = l2_cache_pkg::compare;
            end
        endcase
    end

    always_ff @(posedge clk or posedge n_reset) begin
        if (n_reset) begin
            state    <= l2_cache_pkg::compare;
            l1_ready <= 1'b0;
        end else begin
            state    <= next_state;
            l1_ready <= rd_hit || wr_hit;   // one cycle after the hit
        end
    end

endmodule

//--- design/data_store.sv
`timescale 1ns/100ps

module data_store (
    input  logic                             clk,
    input  logic [l2_cache_pkg::index_w-1:0] index,
    input  logic                             wr_en,
    input  logic                             fill_sel,
    input  logic [l2_cache_pkg::block_w-1:0] l1_wdata,
    input  logic [l2_cache_pkg::block_w-1:0] mem_rdata,
    input  logic                             rd_capture,
    output logic [l2_cache_pkg::block_w-1:0] line,
    output logic [l2_cache_pkg::block_w-1:0] l1_rdata
);

    logic [l2_cache_pkg::block_w-1:0] blocks [l2_cache_pkg::num_lines];
    logic [l2_cache_pkg::block_w-1:0] wr_data;

    // fill takes memory data, write hit takes requester data
    assign wr_data = fill_sel ? mem_rdata : l1_wdata;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            blocks[index] <= wr_data;       // whole block every time
        end
    end

    // indexed line, also the write-back data
    assign line = blocks[index];

    always_ff @(posedge clk) begin
        if (rd_capture) begin
            l1_rdata <= line;
        end
    end

endmodule

//--- design/tag_store.sv
`timescale 1ns/100ps

module tag_store (
    input  logic                             clk,
    input  logic                             n_reset,
    input  logic [l2_cache_pkg::index_w-1:0] index,
    input  logic [l2_cache_pkg::tag_w-1:0]   tag,
    tag_if.store                             tags
);

    logic [l2_cache_pkg::num_lines-1:0] valid;
    logic [l2_cache_pkg::num_lines-1:0] dirty;
    logic [l2_cache_pkg::tag_w-1:0]     tag_mem [l2_cache_pkg::num_lines];

    // lookup is purely combinational on the current address
    assign tags.line_valid = valid[index];
    assign tags.line_dirty = dirty[index];
    assign tags.victim_tag = tag_mem[index];
    assign tags.hit        = valid[index] && (tag_mem[index] == tag);

    // only the valid bits come out of reset
    always_ff @(posedge clk or posedge n_reset) begin
        if (n_reset) begin
            valid <= '0;
        end else if (tags.fill_en) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tags.fill_en) begin
            dirty[index] <= 1'b0;           // fresh from memory
        end else if (tags.set_dirty) begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tags.fill_en) begin
            tag_mem[index] <= tag;
        end
    end

endmodule

//--- design/tag_if.sv
`timescale 1ns/100ps

interface tag_if;

    // lookup results for the current request index
    logic                           hit;
    logic                           line_valid;
    logic                           line_dirty;
    logic [l2_cache_pkg::tag_w-1:0] victim_tag;

    // single-cycle update strobes
    logic                           fill_en;    // valid, clean, new tag
    logic                           set_dirty;

    modport ctrl (
        input  hit,
        input  line_valid,
        input  line_dirty,
        input  victim_tag,
        output fill_en,
        output set_dirty
    );

    modport store (
        output hit,
        output line_valid,
        output line_dirty,
        output victim_tag,
        input  fill_en,
        input  set_dirty
    );

endinterface

//--- design/l2_cache_pkg.sv
package l2_cache_pkg;

    // cache geometry
    localparam int addr_w    = 28;              // block address
    localparam int index_w   = 7;
    localparam int tag_w     = addr_w - index_w;
    localparam int block_w   = 128;             // one block per line
    localparam int num_lines = 1 << index_w;

    // controller states
    typedef enum logic [1:0] {
        compare,                                // lookup, also idle
        write_back,                             // victim going to memory
        fill                                    // new block coming from memory
    } ctrl_state_t;

    // one block address, read flat for memory or split for lookup
    typedef union packed {
        logic [addr_w-1:0] flat;
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
        } fields;
    } block_addr_u;

endpackage
